/* Bender.yml */
package:
  name: stream_proc

sources:
  - common/stream_pkg.sv
  - logic/cmd_packer.sv
  - stream_fifo/stream_fifo.sv
  - logic/accum_unit.sv
  - logic/stream_top.sv
  - target: test
    files:
      - bench/stream_tb.sv

/* bench/stream_patterns.txt */
// kind[19:18]: 0 word, 1 stall start (low 16 bits = idle cycles before release), 2 stall end, 3 end
// word: opcode[17:16] 0 add, 1 sub, 2 xor, 3 load; operand[15:0]
30005   // load 5
00007   // add 7
1000D   // sub 13, wraps below zero
00002   // add 2, wraps past ffff
2AAAA   // xor
3FFFF   // load max operand
0FFFF   // add max operand
10000   // sub zero
2FFFF   // xor all ones
30000   // load zero
40010   // stall start, release after 16 idle cycles
00011
01234
1000F
28000
3BEEF
00100
10101
2F0F0
0ABCD
18000
07FFF
30042
80000   // stall end
0FFFE
10003
2000F
00001
C0000   // end of list

/* bench/stream_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module stream_tb;

    // the path holds a full FIFO plus the packer and result registers.
    localparam int PATH_CAP  = stream_pkg::FIFO_DEPTH + 2;
    localparam int MAX_PAT   = 64;
    localparam int PREFILL_N = 3;
    localparam int REPLAY_N  = 6;
    // entry kinds in the top two bits of each pattern entry.
    localparam logic [1:0] K_WORD    = 2'd0;
    localparam logic [1:0] K_STALL   = 2'd1;
    localparam logic [1:0] K_RELEASE = 2'd2;
    localparam logic [1:0] K_END     = 2'd3;

    logic                         ACLK = 1'b0;
    logic                         ARESETn;
    logic [stream_pkg::RAW_W-1:0] raw_i;
    logic                         raw_valid_i;
    logic                         raw_ready_o;
    stream_pkg::result_t          result_o;
    logic                         result_valid_o;
    logic                         result_ready_i;

    logic [19:0] patterns [MAX_PAT];
    // expected results as {tag, accumulator} with the oldest first.
    logic [19:0] expected_q [$];
    logic [15:0] model_acc;
    logic [3:0]  model_tag;
    logic [31:0] lcg_state;
    int cycles = 0;
    int cycle_limit = 0;
    int accepted_n, results_n, tag_errors, value_errors, pass_count, fail_count;
    int hold_len, low_run, stall_taken, stall_expect, stall_id;
    bit stalled, hold_output, in_replay, took_input;

    always #20 ACLK = ~ACLK;

    stream_top uut (
        .ACLK           (ACLK),
        .ARESETn        (ARESETn),
        .raw_i          (raw_i),
        .raw_valid_i    (raw_valid_i),
        .raw_ready_o    (raw_ready_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

    // watchdog whose limit is set once the pattern file is scanned.
    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge ACLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // opcode rules with all arithmetic wrapping at 16 bits.
    function automatic logic [15:0] apply_op(input logic [15:0] acc, input logic [1:0] op,
                                             input logic [15:0] operand);
        case (op)
            2'd0:    return acc + operand;
            2'd1:    return acc - operand;
            2'd2:    return acc ^ operand;
            default: return operand;
        endcase
    endfunction

    // words between a stall marker and its release marker.
    function automatic int count_phase_words(input int start);
        int n;
        n = 0;
        for (int i = start + 1; i < MAX_PAT && patterns[i][19:18] == K_WORD; i++) begin
            n++;
        end
        return n;
    endfunction

    task automatic report_test(input string name, input int errors);
        if (errors == 0) begin
            $display("test %s: pass", name);
            pass_count++;
        end else begin
            $display("test %s: fail with %0d errors", name, errors);
            fail_count++;
        end
    endtask

    // sampled at the falling edge where both handshakes are settled.
    task automatic observe;
        logic [19:0] want;
        took_input = 1'b0;
        if (raw_valid_i && raw_ready_o) begin
            model_acc = apply_op(model_acc, raw_i[17:16], raw_i[15:0]);
            expected_q.push_back({model_tag, model_acc});
            model_tag++;
            accepted_n++;
            took_input = 1'b1;
        end
        if (result_valid_o && result_ready_i) begin
            results_n++;
            if (expected_q.size() == 0) begin
                $display("a result arrived with no accepted input left to match it");
                tag_errors++;
            end else begin
                want = expected_q.pop_front();
                if (result_o.seq !== want[19:16]) begin
                    $display("error %s: expected tag %h actual %h",
                             in_replay ? "reset" : "order_tags", want[19:16], result_o.seq);
                    tag_errors++;
                end
                if (result_o.acc !== want[15:0]) begin
                    $display("error %s: expected acc %h actual %h",
                             in_replay ? "reset" : "arithmetic", want[15:0], result_o.acc);
                    value_errors++;
                end
            end
        end
    endtask

    // one clock of sampling, stall tracking and driving output ready after the edge.
    task automatic step_cycle;
        @(negedge ACLK);
        observe();
        if (stalled) begin
            if (took_input) begin
                stall_taken++;
                low_run = 0;
            end else begin
                low_run++;
            end
            // input side frozen long enough means the path is full.
            if (low_run >= hold_len) begin
                stalled = 1'b0;
                if (stall_taken != stall_expect) begin
                    $display("error full_path_%0d: expected %0d accepts actual %0d",
                             stall_id, stall_expect, stall_taken);
                end
                report_test($sformatf("full_path_%0d", stall_id),
                            (stall_taken != stall_expect) ? 1 : 0);
            end
        end
        @(posedge ACLK);
        #1;
        lcg_state = lcg_next(lcg_state);
        result_ready_i = (stalled || hold_output) ? 1'b0 : lcg_state[24];
    endtask

    task automatic run_patterns;
        int idx;
        idx = 0;
        while (idx < MAX_PAT && patterns[idx][19:18] != K_END) begin
            case (patterns[idx][19:18])
                K_WORD: begin
                    raw_i       = patterns[idx][17:0];
                    raw_valid_i = 1'b1;
                    step_cycle();
                    if (took_input) idx++;
                end
                K_STALL: begin
                    raw_valid_i = 1'b0;
                    // a stall phase starts on an empty path.
                    if (expected_q.size() == 0) begin
                        stalled        = 1'b1;
                        result_ready_i = 1'b0;
                        hold_len       = patterns[idx][15:0];
                        low_run        = 0;
                        stall_taken    = 0;
                        stall_id++;
                        stall_expect   = count_phase_words(idx);
                        if (stall_expect > PATH_CAP) stall_expect = PATH_CAP;
                        idx++;
                    end else begin
                        step_cycle();
                    end
                end
                K_RELEASE: begin
                    raw_valid_i = 1'b0;
                    if (stalled) step_cycle();
                    else idx++;
                end
            endcase
        end
        raw_valid_i = 1'b0;
    endtask

    task automatic drain;
        raw_valid_i = 1'b0;
        while (expected_q.size() != 0) step_cycle();
    endtask

    initial begin
        int n_words;
        int total_hold;
        int err_base;
        int reset_errors;
        n_words = 0;
        total_hold = 0;
        reset_errors = 0;
        ARESETn = 1'b0;
        raw_i = '0;
        raw_valid_i = 1'b0;
        result_ready_i = 1'b0;
        model_acc = '0;
        model_tag = '0;
        lcg_state = 32'd98;
        {accepted_n, results_n, tag_errors, value_errors} = '0;
        {pass_count, fail_count, stall_id} = '0;
        {stalled, hold_output, in_replay, took_input} = '0;
        for (int i = 0; i < MAX_PAT; i++) patterns[i] = {K_END, 18'h0};
        $readmemh("bench/stream_patterns.txt", patterns);
        for (int i = 0; i < MAX_PAT && patterns[i][19:18] != K_END; i++) begin
            if (patterns[i][19:18] == K_WORD) n_words++;
            else if (patterns[i][19:18] == K_STALL) total_hold += patterns[i][15:0];
        end
        cycle_limit = 20 * (n_words + PREFILL_N + REPLAY_N) + total_hold + 100;
        repeat (8) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;

        run_patterns();
        drain();
        report_test("order_tags", tag_errors);
        report_test("arithmetic", value_errors);
        if (results_n != accepted_n) begin
            $display("error backpressure: expected %0d results actual %0d", accepted_n, results_n);
        end
        report_test("backpressure", (results_n != accepted_n) ? 1 : 0);

        // park a few results in the path so reset has state to clear.
        hold_output = 1'b1;
        result_ready_i = 1'b0;
        raw_valid_i = 1'b1;
        for (int i = 0; i < PREFILL_N; i++) begin
            raw_i = {2'd0, 16'(i + 1)};
            do step_cycle(); while (!took_input);
        end
        raw_valid_i = 1'b0;
        while (!result_valid_o) step_cycle();
        ARESETn = 1'b0;
        repeat (8) begin
            @(negedge ACLK);
            if (result_valid_o) begin
                $display("result_valid_o was high while reset was held");
                reset_errors++;
            end
            @(posedge ACLK);
            #1;
        end
        ARESETn = 1'b1;
        // model restarts from the reset state.
        expected_q.delete();
        model_acc = '0;
        model_tag = '0;
        hold_output = 1'b0;
        in_replay = 1'b1;
        err_base = tag_errors + value_errors;
        raw_valid_i = 1'b1;
        for (int i = 0; i < REPLAY_N; i++) begin
            lcg_state = lcg_next(lcg_state);
            raw_i = {2'd0, lcg_state[31:16]};
            do step_cycle(); while (!took_input);
        end
        drain();
        reset_errors += tag_errors + value_errors - err_base;
        report_test("reset", reset_errors);

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/stream_pkg.sv */
`default_nettype none

package stream_pkg;

    // operand and accumulator width.
    localparam int OPERAND_W = 16;
    // sequence tag width, wraps modulo 16.
    localparam int SEQ_W = 4;
    // raw word is opcode on top of operand.
    localparam int OPCODE_W = 2;
    localparam int RAW_W = OPCODE_W + OPERAND_W;
    // default buffer depth between packer and consumer.
    localparam int FIFO_DEPTH = 8;

    // every 2-bit value is a legal opcode.
    typedef enum logic [OPCODE_W-1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_XOR  = 2'd2,
        OP_LOAD = 2'd3
    } opcode_e;

    // tagged command as it travels through the FIFO.
    typedef struct packed {
        opcode_e              opcode;
        logic [SEQ_W-1:0]     seq;
        logic [OPERAND_W-1:0] operand;
    } cmd_t;

    // result word, tag of the command plus new accumulator.
    typedef struct packed {
        logic [SEQ_W-1:0]     seq;
        logic [OPERAND_W-1:0] acc;
    } result_t;

    // consumer output register occupancy.
    typedef enum logic {ACC_EMPTY = 1'b0, ACC_FULL = 1'b1} acc_state_e;

endpackage

`default_nettype wire

/* logic/accum_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module accum_unit (
    input  wire logic             ACLK,
    input  wire logic             ARESETn,
    input  wire stream_pkg::cmd_t cmd_i,
    input  wire logic             cmd_valid_i,
    output logic                  cmd_ready_o,
    output stream_pkg::result_t   result_o,
    output logic                  result_valid_o,
    input  wire logic             result_ready_i
);

    // whether a result waits in the output register.
    stream_pkg::acc_state_e           state_q;
    // running accumulator that resets to zero.
    logic [stream_pkg::OPERAND_W-1:0] acc_q;
    logic [stream_pkg::OPERAND_W-1:0] acc_next;
    stream_pkg::result_t              result_q;
    logic                             pop;

    // take a command only if the result slot frees up this cycle.
    assign cmd_ready_o    = (state_q == stream_pkg::ACC_EMPTY) || result_ready_i;
    assign pop            = cmd_valid_i && cmd_ready_o;
    assign result_o       = result_q;
    assign result_valid_o = (state_q == stream_pkg::ACC_FULL);

    // arithmetic wraps at the operand width.
    always_comb begin
        case (cmd_i.opcode)
            stream_pkg::OP_ADD:  acc_next = acc_q + cmd_i.operand;
            stream_pkg::OP_SUB:  acc_next = acc_q - cmd_i.operand;
            stream_pkg::OP_XOR:  acc_next = acc_q ^ cmd_i.operand;
            stream_pkg::OP_LOAD: acc_next = cmd_i.operand;
            default:             acc_next = acc_q;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= stream_pkg::ACC_EMPTY;
            acc_q   <= '0;
        end else begin
            if (pop) begin
                state_q <= stream_pkg::ACC_FULL;
                acc_q   <= acc_next;
            end else if (result_ready_i) begin
                // result taken with nothing new to replace it.
                state_q <= stream_pkg::ACC_EMPTY;
            end
        end
    end

    // latch new value with the tag of the command that made it.
    always_ff @(posedge ACLK) begin
        if (pop) begin
            result_q.seq <= cmd_i.seq;
            result_q.acc <= acc_next;
        end
    end

    // a stalled result stays valid and unchanged.
    a_result_stable: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (result_valid_o && !result_ready_i) |=> (result_valid_o && $stable(result_o))
    ) else $error("accum_unit: result changed while stalled");

endmodule

`default_nettype wire

/* logic/cmd_packer.sv */
`default_nettype none
`timescale 1ns/1ps

module cmd_packer (
    input  wire logic                            ACLK,
    input  wire logic                            ARESETn,
    input  wire logic [stream_pkg::RAW_W-1:0]    raw_i,
    input  wire logic                            raw_valid_i,
    output logic                                 raw_ready_o,
    output stream_pkg::cmd_t                     cmd_o,
    output logic                                 cmd_valid_o,
    input  wire logic                            cmd_ready_i
);

    // output register and its occupancy flag.
    stream_pkg::cmd_t             cmd_q;
    logic                         valid_q;
    // running tag, one step per accepted word.
    logic [stream_pkg::SEQ_W-1:0] seq_q;
    logic                         accept;

    // room when empty or when the held command leaves this cycle.
    assign raw_ready_o = !valid_q || cmd_ready_i;
    assign accept      = raw_valid_i && raw_ready_o;

    assign cmd_o       = cmd_q;
    assign cmd_valid_o = valid_q;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            valid_q <= 1'b0;
            seq_q   <= '0;
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
                seq_q   <= seq_q + 1'b1;
            end else if (cmd_ready_i) begin
                // drained with nothing new behind it.
                valid_q <= 1'b0;
            end
        end
    end

    // split the raw word and stamp it with the current tag.
    always_ff @(posedge ACLK) begin
        if (accept) begin
            cmd_q.opcode  <= stream_pkg::opcode_e'(
                raw_i[stream_pkg::RAW_W-1 -: stream_pkg::OPCODE_W]);
            cmd_q.seq     <= seq_q;
            cmd_q.operand <= raw_i[stream_pkg::OPERAND_W-1:0];
        end
    end

    // a stalled command must hold both valid and payload.
    a_cmd_stable: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        (cmd_valid_o && !cmd_ready_i) |=> (cmd_valid_o && $stable(cmd_o))
    ) else $error("cmd_packer: command changed while stalled");

endmodule

`default_nettype wire

/* logic/stream_top.sv */
`default_nettype none
`timescale 1ns/1ps

module stream_top (
    input  wire logic                         ACLK,
    input  wire logic                         ARESETn,
    input  wire logic [stream_pkg::RAW_W-1:0] raw_i,
    input  wire logic                         raw_valid_i,
    output logic                              raw_ready_o,
    output stream_pkg::result_t               result_o,
    output logic                              result_valid_o,
    input  wire logic                         result_ready_i
);

    // packer to buffer link.
    stream_pkg::cmd_t pack_cmd;
    logic             pack_valid;
    logic             pack_ready;

    // buffer to consumer link.
    stream_pkg::cmd_t fifo_cmd;
    logic             fifo_valid;
    logic             fifo_ready;

    // decode and tag incoming words.
    cmd_packer u_packer (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .raw_i       (raw_i),
        .raw_valid_i (raw_valid_i),
        .raw_ready_o (raw_ready_o),
        .cmd_o       (pack_cmd),
        .cmd_valid_o (pack_valid),
        .cmd_ready_i (pack_ready)
    );

    // queue tagged commands.
    stream_fifo #(
        .DEPTH (stream_pkg::FIFO_DEPTH)
    ) u_fifo (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .data_i  (pack_cmd),
        .valid_i (pack_valid),
        .ready_o (pack_ready),
        .data_o  (fifo_cmd),
        .valid_o (fifo_valid),
        .ready_i (fifo_ready)
    );

    // execute commands and present results.
    accum_unit u_accum (
        .ACLK           (ACLK),
        .ARESETn        (ARESETn),
        .cmd_i          (fifo_cmd),
        .cmd_valid_i    (fifo_valid),
        .cmd_ready_o    (fifo_ready),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

endmodule

`default_nettype wire

/* stream_fifo/stream_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

module stream_fifo #(
    parameter int DEPTH = stream_pkg::FIFO_DEPTH
) (
    input  wire logic             ACLK,
    input  wire logic             ARESETn,

    input  wire stream_pkg::cmd_t data_i,
    input  wire logic             valid_i,
    output logic                  ready_o,

    output stream_pkg::cmd_t      data_o,
    output logic                  valid_o,
    input  wire logic             ready_i
);

    localparam int ADDR_W = $clog2(DEPTH);

    // storage that is written only on an accepted push.
    stream_pkg::cmd_t  fifo_mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    // one bit wider than the pointers so full is representable.
    logic [ADDR_W:0]   count;
    logic              push;
    logic              pop;

    assign push = valid_i && ready_o;
    assign pop  = valid_o && ready_i;

    // head of queue read straight from the read pointer.
    assign data_o  = fifo_mem[rd_ptr];
    assign valid_o = (count != '0);
    assign ready_o = (count < (ADDR_W+1)'(DEPTH));

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the count alone.
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (push) begin
            fifo_mem[wr_ptr] <= data_i;
        end
    end

    // occupancy never passes the depth.
    a_count_bound: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        count <= (ADDR_W+1)'(DEPTH)
    ) else $error("stream_fifo: count above DEPTH");

    // a pop reads a written slot, so the pointers only meet when full.
    a_no_empty_pop: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        pop |-> ((rd_ptr != wr_ptr) || (count == (ADDR_W+1)'(DEPTH)))
    ) else $error("stream_fifo: pop from empty buffer");

endmodule

`default_nettype wire

/* stream_proc.f */
common/stream_pkg.sv
logic/cmd_packer.sv
stream_fifo/stream_fifo.sv
logic/accum_unit.sv
logic/stream_top.sv
bench/stream_tb.sv
